//--- Bender.yml
package:
  name: raytest_display

sources:
  # package first, then the pipeline stages, then the top level
  - hdl/raytest_pkg.sv
  - hdl/vector_capture.sv
  - hdl/word_stepper.sv
  - hdl/hex_display.sv
  - hdl/raytest_display_top.sv
  - target: test
    files:
      - testbench/raytest_tb.sv

//--- hdl/hex_display.sv
`timescale 1ns/1ps

module hex_display
   import raytest_pkg::*;
(
   input  logic              sdr_clk,
   input  logic              sdr_reset,
   input  logic [WORD_W-1:0] raytest_data,
   output seg_t              hex0,
   output seg_t              hex1,
   output seg_t              hex2,
   output seg_t              hex3,
   output seg_t              hex4,
   output seg_t              hex5
);

   // digits of the reset word, for the register reset value
   localparam display_word_t RESET_VIEW = RESET_WORD;

   display_word_t shown;
   seg_t          seg_q [HEX_DIGITS];

   ////////////////////////////////////////
   // nibble to segment table
   ////////////////////////////////////////

   // active low, gfedcba order
   function automatic seg_t seg_decode(input logic [NIBBLE_W-1:0] digit);
      seg_t seg;
      case (digit)
         4'h0:    seg = 7'b1000000;
         4'h1:    seg = 7'b1111001;
         4'h2:    seg = 7'b0100100;
         4'h3:    seg = 7'b0110000;
         4'h4:    seg = 7'b0011001;
         4'h5:    seg = 7'b0010010;
         4'h6:    seg = 7'b0000010;
         4'h7:    seg = 7'b1111000;
         4'h8:    seg = 7'b0000000;
         4'h9:    seg = 7'b0010000;
         4'hA:    seg = 7'b0001000;
         4'hB:    seg = 7'b0000011;
         4'hC:    seg = 7'b1000110;
         4'hD:    seg = 7'b0100001;
         4'hE:    seg = 7'b0000110;
         default: seg = 7'b0001110;
      endcase
      return seg;
   endfunction

   // word in, digits out
   assign shown.word = raytest_data;

   // one register stage after the decode
   always_ff @(posedge sdr_clk or posedge sdr_reset) begin
      if (sdr_reset) begin
         for (int k = 0; k < HEX_DIGITS; k++) begin
            seg_q[k] <= seg_decode(RESET_VIEW.nib[k]);
         end
      end else begin
         for (int k = 0; k < HEX_DIGITS; k++) begin
            seg_q[k] <= seg_decode(shown.nib[k]);
         end
      end
   end

   // digit k shows nibble k
   assign hex0 = seg_q[0];
   assign hex1 = seg_q[1];
   assign hex2 = seg_q[2];
   assign hex3 = seg_q[3];
   assign hex4 = seg_q[4];
   assign hex5 = seg_q[5];

endmodule

//--- hdl/raytest_display_top.sv
`timescale 1ns/1ps

module raytest_display_top
   import raytest_pkg::*;
#(
   parameter int VEC_WORDS = 4,
   parameter int TICK_DIV  = 50_000_000
) (
   input  logic                          sdr_clk,
   input  logic                          sdr_reset,
   input  logic [VEC_WORDS*WORD_W-1:0]   raytest_wire,
   input  logic                          raytest_en,
   output seg_t                          hex0,
   output seg_t                          hex1,
   output seg_t                          hex2,
   output seg_t                          hex3,
   output seg_t                          hex4,
   output seg_t                          hex5,
   output logic                          more_than_one
);

   // capture -> step
   logic [VEC_WORDS*WORD_W-1:0] raytest_vec;
   logic                        start_raytest;
   // step -> display
   logic [WORD_W-1:0]           raytest_data;

   ////////////////////////////////////////
   // pipeline, capture -> step -> display
   ////////////////////////////////////////

   vector_capture #(
      .VEC_WORDS     (VEC_WORDS)
   ) vector_capture_i (
      .sdr_clk       (sdr_clk),
      .sdr_reset     (sdr_reset),
      .raytest_wire  (raytest_wire),
      .raytest_en    (raytest_en),
      .raytest_vec   (raytest_vec),
      .start_raytest (start_raytest),
      .more_than_one (more_than_one)
   );

   // slow tick lives in here, same clock
   word_stepper #(
      .VEC_WORDS     (VEC_WORDS),
      .TICK_DIV      (TICK_DIV)
   ) word_stepper_i (
      .sdr_clk       (sdr_clk),
      .sdr_reset     (sdr_reset),
      .raytest_vec   (raytest_vec),
      .start_raytest (start_raytest),
      .raytest_data  (raytest_data)
   );

   hex_display hex_display_i (
      .sdr_clk       (sdr_clk),
      .sdr_reset     (sdr_reset),
      .raytest_data  (raytest_data),
      .hex0          (hex0),
      .hex1          (hex1),
      .hex2          (hex2),
      .hex3          (hex3),
      .hex4          (hex4),
      .hex5          (hex5)
   );

endmodule

//--- hdl/raytest_pkg.sv
package raytest_pkg;

   ////////////////////////////////////////
   // widths and counts
   ////////////////////////////////////////

   // one test word from the host bus
   localparam int WORD_W     = 32;
   // one hex digit
   localparam int NIBBLE_W   = 4;
   // nibbles in one word
   localparam int NIBBLES    = WORD_W / NIBBLE_W;
   // segments a..g
   localparam int SEG_W      = 7;
   // digits on the board
   localparam int HEX_DIGITS = 6;

   // shown before any vector is stepped
   localparam logic [WORD_W-1:0] RESET_WORD = 32'h0000_DEAD;

   ////////////////////////////////////////
   // types
   ////////////////////////////////////////

   // displayed word, whole or split into hex digits
   // nib[0] is the least significant digit
   typedef union packed {
      logic [WORD_W-1:0]                  word;
      logic [NIBBLES-1:0][NIBBLE_W-1:0]  nib;
   } display_word_t;

   // one digit, active low
   // bit 0 is segment a, bit 6 is segment g
   typedef logic [SEG_W-1:0] seg_t;

endpackage

//--- hdl/vector_capture.sv
`timescale 1ns/1ps

module vector_capture
   import raytest_pkg::*;
#(
   parameter int VEC_WORDS = 4
) (
   input  logic                          sdr_clk,
   input  logic                          sdr_reset,
   input  logic [VEC_WORDS*WORD_W-1:0]   raytest_wire,
   input  logic                          raytest_en,
   output logic [VEC_WORDS*WORD_W-1:0]   raytest_vec,
   output logic                          start_raytest,
   output logic                          more_than_one
);

   ////////////////////////////////////////
   // vector latch
   ////////////////////////////////////////

   // every strobe recaptures, also while stepping
   always_ff @(posedge sdr_clk or posedge sdr_reset) begin
      if (sdr_reset) begin
         raytest_vec <= '0;
      end else if (raytest_en) begin
         raytest_vec <= raytest_wire;
      end
   end

   ////////////////////////////////////////
   // start and repeat flags
   ////////////////////////////////////////

   // both sticky until reset
   always_ff @(posedge sdr_clk or posedge sdr_reset) begin
      if (sdr_reset) begin
         start_raytest <= 1'b0;
         more_than_one <= 1'b0;
      end else if (raytest_en) begin
         // second strobe seen, start was already up before this edge
         if (start_raytest) begin
            more_than_one <= 1'b1;
         end
         start_raytest <= 1'b1;
      end
   end

   // repeat flag can only follow a start
   a_repeat_after_start : assert property (
      @(posedge sdr_clk) disable iff (sdr_reset)
      more_than_one |-> start_raytest
   );

endmodule

//--- hdl/word_stepper.sv
`timescale 1ns/1ps

module word_stepper
   import raytest_pkg::*;
#(
   parameter int VEC_WORDS = 4,
   parameter int TICK_DIV  = 50_000_000
) (
   input  logic                          sdr_clk,
   input  logic                          sdr_reset,
   input  logic [VEC_WORDS*WORD_W-1:0]   raytest_vec,
   input  logic                          start_raytest,
   output logic [WORD_W-1:0]             raytest_data
);

   // counter needs at least one bit, even for TICK_DIV of 1
   localparam int CNT_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
   // index runs 0..VEC_WORDS inclusive
   localparam int ADDR_W = $clog2(VEC_WORDS + 1);

   localparam logic [CNT_W-1:0]  TICK_LAST = CNT_W'(TICK_DIV - 1);
   localparam logic [ADDR_W-1:0] ADDR_END  = ADDR_W'(VEC_WORDS);

   logic [CNT_W-1:0]  tick_cnt;
   logic              tick;
   logic [ADDR_W-1:0] raytest_addr;

   ////////////////////////////////////////
   // rate divider
   ////////////////////////////////////////

   // free running, start flag does not matter here
   assign tick = (tick_cnt == TICK_LAST);

   always_ff @(posedge sdr_clk or posedge sdr_reset) begin
      if (sdr_reset) begin
         tick_cnt <= '0;
      end else if (tick) begin
         tick_cnt <= '0;
      end else begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // word walk
   ////////////////////////////////////////

   // one word per tick, read from the live vector
   // index parks at VEC_WORDS until reset
   always_ff @(posedge sdr_clk or posedge sdr_reset) begin
      if (sdr_reset) begin
         raytest_addr <= '0;
         raytest_data <= RESET_WORD;
      end else if (tick && start_raytest && (raytest_addr != ADDR_END)) begin
         raytest_data <= raytest_vec[raytest_addr*WORD_W +: WORD_W];
         raytest_addr <= raytest_addr + 1'b1;
      end
   end

   // index never runs past the end
   a_addr_in_range : assert property (
      @(posedge sdr_clk) disable iff (sdr_reset)
      raytest_addr <= ADDR_END
   );

   // display word only moves on a tick edge
   a_data_on_tick : assert property (
      @(posedge sdr_clk) disable iff (sdr_reset)
      $changed(raytest_data) |-> $past(tick)
   );

endmodule

//--- src.f
hdl/raytest_pkg.sv
hdl/vector_capture.sv
hdl/word_stepper.sv
hdl/hex_display.sv
hdl/raytest_display_top.sv
testbench/raytest_tb.sv

//--- testbench/raytest_tb.sv
`timescale 1ns/1ps

module raytest_tb;

   localparam int VEC_WORDS   = 4;
   localparam int TICK_DIV    = 5;
   localparam int WORD_W      = 32;
   localparam int CYCLE_LIMIT = 2000;

   // word on the digits before anything is stepped
   localparam logic [WORD_W-1:0] IDLE_WORD = 32'h0000_DEAD;

   // active low gfedcba, entry 15 first
   localparam logic [15:0][6:0] SEG_TABLE = {
      7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
      7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
   };

   // starts low without an edge at time zero
   logic                        sdr_clk = 1'b0;
   logic                        sdr_reset;
   logic [VEC_WORDS*WORD_W-1:0] raytest_wire;
   logic                        raytest_en;
   logic [6:0]                  hex0, hex1, hex2, hex3, hex4, hex5;
   logic                        more_than_one;
   logic [6:0]                  hex_out [6];

   // reference state
   int                          m_cnt;
   int                          m_addr;
   logic                        m_tick;
   logic                        m_last_tick;
   logic                        m_start;
   logic                        m_more;
   logic [VEC_WORDS*WORD_W-1:0] m_vec;
   logic [WORD_W-1:0]           m_data;
   logic [WORD_W-1:0]           m_disp;

   int                          cycle_count = 0;

   raytest_display_top #(
      .VEC_WORDS     (VEC_WORDS),
      .TICK_DIV      (TICK_DIV)
   ) raytest_display_top_i (
      .sdr_clk       (sdr_clk),
      .sdr_reset     (sdr_reset),
      .raytest_wire  (raytest_wire),
      .raytest_en    (raytest_en),
      .hex0          (hex0),
      .hex1          (hex1),
      .hex2          (hex2),
      .hex3          (hex3),
      .hex4          (hex4),
      .hex5          (hex5),
      .more_than_one (more_than_one)
   );

   assign hex_out[0] = hex0;
   assign hex_out[1] = hex1;
   assign hex_out[2] = hex2;
   assign hex_out[3] = hex3;
   assign hex_out[4] = hex4;
   assign hex_out[5] = hex5;

   // 10 ns period
   always #5 sdr_clk = ~sdr_clk;

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   assign m_tick = (m_cnt == TICK_DIV - 1);

   always @(posedge sdr_clk or posedge sdr_reset) begin
      if (sdr_reset) begin
         m_cnt       <= 0;
         m_addr      <= 0;
         m_last_tick <= 1'b0;
         m_start     <= 1'b0;
         m_more      <= 1'b0;
         m_vec       <= '0;
         m_data      <= IDLE_WORD;
         m_disp      <= IDLE_WORD;
      end else begin
         // slow tick, wraps at TICK_DIV
         m_last_tick <= m_tick;
         m_cnt       <= m_tick ? 0 : m_cnt + 1;
         // strobe latches vector, flags are sticky
         if (raytest_en) begin
            m_vec   <= raytest_wire;
            m_more  <= m_more | m_start;
            m_start <= 1'b1;
         end
         // one word per tick once started
         if (m_tick && m_start && m_addr < VEC_WORDS) begin
            m_data <= m_vec[m_addr*WORD_W +: WORD_W];
            m_addr <= m_addr + 1;
         end
         // digits follow one cycle later
         m_disp <= m_data;
      end
   end

   ////////////////////////////////////////
   // checking helpers
   ////////////////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else fail_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
   endtask

   // all six digits against the nibbles of one word
   task automatic expect_word(input logic [WORD_W-1:0] w);
      for (int k = 0; k < 6; k++) begin
         check_value($sformatf("hex%0d", k), SEG_TABLE[w[k*4 +: 4]], hex_out[k]);
      end
   endtask

   // every cycle, away from both edges of the stimulus
   always @(negedge sdr_clk) begin
      expect_word(m_disp);
      check_value("more_than_one", m_more, more_than_one);
   end

   // hang guard
   always @(posedge sdr_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         fail_run($sformatf("timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   function automatic logic [VEC_WORDS*WORD_W-1:0] random_vec();
      logic [VEC_WORDS*WORD_W-1:0] v;
      for (int k = 0; k < VEC_WORDS; k++) begin
         v[k*WORD_W +: WORD_W] = $urandom;
      end
      return v;
   endfunction

   // inputs move 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge sdr_clk);
      #1;
   endtask

   // returns just after the edge that was a tick
   task automatic wait_tick();
      do begin
         next_cycle();
      end while (!m_last_tick);
   endtask

   task automatic apply_reset();
      sdr_reset = 1'b1;
      repeat (2) next_cycle();
      sdr_reset = 1'b0;
   endtask

   // single strobe, returns once it is latched
   task automatic strobe_vector(input logic [VEC_WORDS*WORD_W-1:0] v);
      raytest_wire = v;
      raytest_en   = 1'b1;
      next_cycle();
      raytest_en   = 1'b0;
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      logic [VEC_WORDS*WORD_W-1:0] vec;

      sdr_reset    = 1'b1;
      raytest_en   = 1'b0;
      raytest_wire = '0;
      void'($urandom(32'h6deb_8925));
      repeat (2) next_cycle();
      sdr_reset = 1'b0;

      // reset state, D A E D 0 0 from hex0 up
      expect_word(IDLE_WORD);
      check_value("more_than_one", 1'b0, more_than_one);

      // busy bus but no strobe
      repeat (50) begin
         raytest_wire = random_vec();
         next_cycle();
      end
      expect_word(IDLE_WORD);

      // one vector stepped word by word
      vec = random_vec();
      strobe_vector(vec);
      for (int k = 0; k < VEC_WORDS; k++) begin
         wait_tick();
         next_cycle();
         expect_word(vec[k*WORD_W +: WORD_W]);
      end
      // parked on the last word
      repeat (3) begin
         wait_tick();
         next_cycle();
         expect_word(vec[(VEC_WORDS-1)*WORD_W +: WORD_W]);
      end
      check_value("more_than_one", 1'b0, more_than_one);

      // second strobe raises the repeat flag
      strobe_vector(random_vec());
      check_value("more_than_one", 1'b1, more_than_one);
      repeat (20) next_cycle();
      check_value("more_than_one", 1'b1, more_than_one);

      // random recaptures while stepping, model tracks the words
      repeat (10) begin
         apply_reset();
         strobe_vector(random_vec());
         repeat (30) begin
            raytest_wire = random_vec();
            raytest_en   = ($urandom_range(3) == 0);
            next_cycle();
         end
         raytest_en = 1'b0;
      end

      // reset partway through, then restart
      apply_reset();
      strobe_vector(random_vec());
      repeat (2) wait_tick();
      sdr_reset = 1'b1;
      next_cycle();
      expect_word(IDLE_WORD);
      check_value("more_than_one", 1'b0, more_than_one);
      next_cycle();
      sdr_reset = 1'b0;
      vec = random_vec();
      strobe_vector(vec);
      wait_tick();
      next_cycle();
      expect_word(vec[WORD_W-1:0]);
      check_value("more_than_one", 1'b0, more_than_one);

      repeat (5) next_cycle();
      $display("No errors");
      $finish;
   end

endmodule
